/* include/hcnt_settings.svh */
//////////////////////////////////////////////////////////////////////
// Build-time settings for the hardened credit counter
// Any file that needs the credit width or the reset credit value
// includes this header and uses the macros directly
//////////////////////////////////////////////////////////////////////

`ifndef HCNT_SETTINGS_SVH
`define HCNT_SETTINGS_SVH

// Bit width of one credit count
// Both counter lanes and the checker sum are sized from this
`define CNT_WIDTH 8

// Primary lane value after reset and after a clear
// The secondary lane starts at the complement of this value
`define RESET_CREDITS 0

`endif

/* hw/hcnt_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared types for the hardened credit counter
// Modules refer to these types by scoped name in their port lists
// and import the package in their body where they need it
//////////////////////////////////////////////////////////////////////

`include "hcnt_settings.svh"

package hcnt_pkg;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  // One credit count as held by a counter lane
  typedef logic [`CNT_WIDTH-1:0] credit_t;

  // Amount by which a lane moves on one committed increment or decrement
  // It has the same width as a count so that a full-scale return fits
  typedef logic [`CNT_WIDTH-1:0] step_t;

  //////////////////////////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////////////////////////

  // ST_UNINIT waits for an init from the link
  // ST_ACTIVE is the only state in which flits are granted
  // ST_FAULT is sticky and only a clear brings the controller back
  typedef enum logic [1:0] {
    ST_UNINIT = 2'b00,
    ST_ACTIVE = 2'b01,
    ST_FAULT  = 2'b10
  } ctrl_state_e;

endpackage

/* hw/cnt_ctrl_if.sv */
//////////////////////////////////////////////////////////////////////
// Command bundle from the credit controller to the counter lanes
// The controller drives it through the ctrl modport and every lane
// listens on the lane modport, so both lanes see the same command
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface cnt_ctrl_if;
  import hcnt_pkg::*;

  // Clear back to the reset credit value, highest priority
  logic    clr;
  // Load set_val, wins over increment and decrement
  logic    set;
  credit_t set_val;
  // Step the primary count up or down by step
  logic    incr;
  logic    decr;
  step_t   step;
  // Lanes only take the new value when this is high
  logic    commit;

  modport ctrl (
    output clr,
    output set,
    output set_val,
    output incr,
    output decr,
    output step,
    output commit
  );

  modport lane (
    input clr,
    input set,
    input set_val,
    input incr,
    input decr,
    input step,
    input commit
  );

endinterface

/* hw/credit_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Credit controller for the link transmitter
// Grants flits while credits are available, merges grants and credit
// returns into one net counter command per cycle and tracks the
// UNINIT, ACTIVE and FAULT states of the credit counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module credit_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clr_i,
  input  logic              init_i,
  input  hcnt_pkg::credit_t init_credits_i,
  input  logic              tx_req_i,
  input  logic              ret_valid_i,
  input  hcnt_pkg::step_t   ret_cnt_i,
  input  hcnt_pkg::credit_t credits_i,
  input  logic              err_i,
  output logic              tx_grant_o,
  cnt_ctrl_if.ctrl          cmd
);
  import hcnt_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // A return only counts when it carries at least one credit
  logic        ret_vld;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  // Clear always wins and the fault state is sticky until then
  always_comb begin
    state_d = state_q;
    if (clr_i) begin
      state_d = ST_UNINIT;
    end else if (err_i || (state_q == ST_FAULT)) begin
      state_d = ST_FAULT;
    end else if (init_i) begin
      state_d = ST_ACTIVE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_UNINIT;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Grant and counter command
  //////////////////////////////////////////////////////////////////////

  // The grant is combinational so the sender can go in the same cycle
  // An init in flight blocks it since the count is about to be replaced
  assign tx_grant_o = tx_req_i && (state_q == ST_ACTIVE) &&
                      (credits_i != '0) && !init_i;

  assign ret_vld = ret_valid_i && (ret_cnt_i != '0);

  // Only one action reaches the lanes per cycle
  // A grant together with a return collapses into a single increment
  always_comb begin
    cmd.clr     = 1'b0;
    cmd.set     = 1'b0;
    cmd.set_val = init_credits_i;
    cmd.incr    = 1'b0;
    cmd.decr    = 1'b0;
    cmd.step    = '0;
    if (clr_i) begin
      cmd.clr = 1'b1;
    end else if (init_i) begin
      cmd.set = 1'b1;
    end else if (tx_grant_o && ret_vld) begin
      // A return of exactly one cancels the grant and nothing moves
      if (ret_cnt_i != step_t'(1)) begin
        cmd.incr = 1'b1;
        cmd.step = ret_cnt_i - step_t'(1);
      end
    end else if (tx_grant_o) begin
      cmd.decr = 1'b1;
      cmd.step = step_t'(1);
    end else if (ret_vld) begin
      cmd.incr = 1'b1;
      cmd.step = ret_cnt_i;
    end
  end

  assign cmd.commit = cmd.clr | cmd.set | cmd.incr | cmd.decr;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // The count seen here comes back from the lanes through the checker
  a_no_grant_without_credit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tx_grant_o |-> (credits_i != '0) && (state_q == ST_ACTIVE)
  ) else $error("grant issued without credit or outside ST_ACTIVE");

  // A lone grant must cost exactly one credit on the next cycle
  a_grant_consumes_one: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    tx_grant_o && !clr_i && !ret_vld
    |=> (credits_i == $past(credits_i) - credit_t'(1)) || err_i
  ) else $error("grant did not consume exactly one credit");

endmodule

/* hw/hard_count_lane.sv */
//////////////////////////////////////////////////////////////////////
// One lane of the hardened credit counter
// With Invert clear it is the primary lane and counts credits up
// With Invert set it holds the complement and moves the other way
// Clear beats set, set beats a step, and nothing moves without commit
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcnt_settings.svh"

module hard_count_lane #(
  parameter bit Invert = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  cnt_ctrl_if.lane          cmd,
  output hcnt_pkg::credit_t cnt_o
);
  import hcnt_pkg::*;

  // Value after reset and after a clear, complemented for the down lane
  localparam credit_t ClrVal = Invert ? ~credit_t'(`RESET_CREDITS) :
                                        credit_t'(`RESET_CREDITS);

  logic                incr_en;
  logic                decr_en;
  credit_t             set_val;
  logic [`CNT_WIDTH:0] ext_cnt;
  logic                oflow;
  logic                uflow;
  credit_t             cnt_sat;
  logic                cnt_en;
  credit_t             cnt_d;
  credit_t             cnt_q;

  // The down lane sees increment and decrement swapped
  assign incr_en = Invert ? cmd.decr : cmd.incr;
  assign decr_en = Invert ? cmd.incr : cmd.decr;
  assign set_val = Invert ? ~cmd.set_val : cmd.set_val;

  //////////////////////////////////////////////////////////////////////
  // Step and saturation
  //////////////////////////////////////////////////////////////////////

  // One extra bit catches both the carry out and the borrow
  assign ext_cnt = decr_en ? {1'b0, cnt_q} - {1'b0, cmd.step} :
                   incr_en ? {1'b0, cnt_q} + {1'b0, cmd.step} :
                             {1'b0, cnt_q};

  assign oflow = incr_en && ext_cnt[`CNT_WIDTH];
  assign uflow = decr_en && ext_cnt[`CNT_WIDTH];

  // Clamp to the rails instead of wrapping around
  assign cnt_sat = uflow ? '0 :
                   oflow ? '1 : ext_cnt[`CNT_WIDTH-1:0];

  // Stand still when both directions are asked for at once
  // or when the count already sits on the rail it is heading to
  assign cnt_en = (incr_en ^ decr_en) &&
                  ((incr_en && !(&cnt_q)) || (decr_en && (cnt_q != '0)));

  assign cnt_d = cmd.clr ? ClrVal  :
                 cmd.set ? set_val :
                 cnt_en  ? cnt_sat : cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Count register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= ClrVal;
    end else if (cmd.commit) begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_o = cnt_q;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Directions here are the lane's own after the swap
  a_incr_never_lowers: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd.commit && incr_en && !decr_en && !cmd.clr && !cmd.set
    |=> cnt_q >= $past(cnt_q)
  ) else $error("committed increment lowered the lane value");

  a_decr_never_raises: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd.commit && decr_en && !incr_en && !cmd.clr && !cmd.set
    |=> cnt_q <= $past(cnt_q)
  ) else $error("committed decrement raised the lane value");

endmodule

/* hw/count_check.sv */
//////////////////////////////////////////////////////////////////////
// Consistency check across the two counter lanes
// The primary and complement lanes must always add up to all ones
// Any other sum is flagged on err_o one cycle later
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcnt_settings.svh"

module count_check (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  hcnt_pkg::credit_t up_cnt_i,
  input  hcnt_pkg::credit_t dn_cnt_i,
  output hcnt_pkg::credit_t credits_o,
  output logic              err_o
);

  // Widened so that a carry out also counts as a mismatch
  logic [`CNT_WIDTH:0] sum;
  logic                err_d;
  logic                err_q;

  assign sum   = {1'b0, up_cnt_i} + {1'b0, dn_cnt_i};
  assign err_d = (sum != {1'b0, {`CNT_WIDTH{1'b1}}});

  // Error goes through a flop so downstream sees a clean level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= 1'b0;
    end else begin
      err_q <= err_d;
    end
  end

  assign err_o = err_q;

  // The primary lane carries the credit count
  assign credits_o = up_cnt_i;

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  // Both lanes are driven by one command, so without a fault the sum holds
  a_no_lane_mismatch: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !err_o
  ) else $error("lane sum left all ones");

endmodule

/* hw/credit_guard_top.sv */
//////////////////////////////////////////////////////////////////////
// Top level of the hardened credit counter for a link transmitter
// The controller commands two counter lanes in lockstep and the
// checker compares them, all behind plain link side ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module credit_guard_top (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clr_i,
  input  logic              init_i,
  input  hcnt_pkg::credit_t init_credits_i,
  input  logic              tx_req_i,
  input  logic              ret_valid_i,
  input  hcnt_pkg::step_t   ret_cnt_i,
  output logic              tx_grant_o,
  output hcnt_pkg::credit_t credits_o,
  output logic              err_o
);
  import hcnt_pkg::*;

  // Raw lane values before the checker
  credit_t up_cnt;
  credit_t dn_cnt;

  // One command bundle feeds both lanes
  cnt_ctrl_if cnt_cmd ();

  credit_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clr_i          (clr_i),
    .init_i         (init_i),
    .init_credits_i (init_credits_i),
    .tx_req_i       (tx_req_i),
    .ret_valid_i    (ret_valid_i),
    .ret_cnt_i      (ret_cnt_i),
    .credits_i      (credits_o),
    .err_i          (err_o),
    .tx_grant_o     (tx_grant_o),
    .cmd            (cnt_cmd.ctrl)
  );

  // Primary lane counts credits directly
  hard_count_lane #(
    .Invert (1'b0)
  ) u_up_lane (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd    (cnt_cmd.lane),
    .cnt_o  (up_cnt)
  );

  // Secondary lane holds the complement
  hard_count_lane #(
    .Invert (1'b1)
  ) u_dn_lane (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cmd    (cnt_cmd.lane),
    .cnt_o  (dn_cnt)
  );

  count_check u_check (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .up_cnt_i  (up_cnt),
    .dn_cnt_i  (dn_cnt),
    .credits_o (credits_o),
    .err_o     (err_o)
  );

endmodule

/* testbench/tb_credit_guard.sv */
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the hardened credit counter top level
// Directed link sequences are followed by LCG driven random traffic
// A reference model predicts grants and credit counts every cycle
// A watchdog ends the run if the stimulus never completes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcnt_settings.svh"

module tb_credit_guard;
  import hcnt_pkg::*;

  localparam int      ClkPeriod    = 40;
  localparam int      RandCycles   = 400;
  // Upper bound on the directed part, counted generously
  localparam int      DirCycles    = 60;
  localparam int      TimeoutNs    = (RandCycles + DirCycles + 100) * ClkPeriod;
  localparam credit_t ResetCredits = credit_t'(`RESET_CREDITS);
  localparam credit_t FullScale    = '1;

  logic    clk_i;
  logic    rst_ni;
  logic    clr_i;
  logic    init_i;
  credit_t init_credits_i;
  logic    tx_req_i;
  logic    ret_valid_i;
  step_t   ret_cnt_i;
  logic    tx_grant_o;
  credit_t credits_o;
  logic    err_o;

  // Reference model state, updated once per cycle by the compare process
  credit_t     model_cnt;
  logic        model_active;
  logic [31:0] rng_state;

  credit_guard_top dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .clr_i          (clr_i),
    .init_i         (init_i),
    .init_credits_i (init_credits_i),
    .tx_req_i       (tx_req_i),
    .ret_valid_i    (ret_valid_i),
    .ret_cnt_i      (ret_cnt_i),
    .tx_grant_o     (tx_grant_o),
    .credits_o      (credits_o),
    .err_o          (err_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected grant and next state from the link rules
  // Priority is clear, then init, then the net of grant and return
  function automatic void ref_step(
    input  logic    active,
    input  credit_t cnt,
    input  logic    clr,
    input  logic    init,
    input  credit_t init_n,
    input  logic    req,
    input  logic    ret_v,
    input  step_t   ret_n,
    output logic    grant,
    output credit_t cnt_n,
    output logic    active_n
  );
    logic [`CNT_WIDTH:0] wide;
    grant    = req && active && (cnt != '0) && !init;
    cnt_n    = cnt;
    active_n = active;
    wide     = {1'b0, cnt};
    if (clr) begin
      cnt_n    = ResetCredits;
      active_n = 1'b0;
    end else if (init) begin
      cnt_n    = init_n;
      active_n = 1'b1;
    end else begin
      if (ret_v) wide = wide + {1'b0, ret_n};
      if (grant) wide = wide - (`CNT_WIDTH+1)'(1);
      // Returns beyond full scale clamp at all ones
      cnt_n = wide[`CNT_WIDTH] ? FullScale : wide[`CNT_WIDTH-1:0];
    end
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Result: FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // Applies one cycle of link inputs on the next rising edge
  task automatic drive_link(input logic clr, input logic init, input credit_t init_n,
                            input logic req, input logic ret_v, input step_t ret_n);
    @(posedge clk_i);
    clr_i          <= clr;
    init_i         <= init;
    init_credits_i <= init_n;
    tx_req_i       <= req;
    ret_valid_i    <= ret_v;
    ret_cnt_i      <= ret_n;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////////////////////////

  // Falling edge sampling sees inputs and outputs settled
  // The grant is checked in its own cycle, the count one cycle later
  always @(negedge clk_i) begin : compare
    logic    exp_grant;
    credit_t next_cnt;
    logic    next_active;
    if (!rst_ni) begin
      model_cnt    = ResetCredits;
      model_active = 1'b0;
    end
    check_eq("credits_o", 32'(credits_o), 32'(model_cnt));
    check_eq("err_o", 32'(err_o), 32'd0);
    ref_step(model_active, model_cnt, clr_i, init_i, init_credits_i, tx_req_i,
             ret_valid_i, ret_cnt_i, exp_grant, next_cnt, next_active);
    check_eq("tx_grant_o", 32'(tx_grant_o), 32'(exp_grant));
    if (rst_ni) begin
      model_cnt    = next_cnt;
      model_active = next_active;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    #(TimeoutNs);
    $display("Result: FAILED");
    $fatal(1, "Timeout: the test sequence did not finish within %0d ns", TimeoutNs);
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int          grants;
    logic [31:0] r;
    rng_state      = 32'h690c;
    rst_ni         = 1'b0;
    clr_i          = 1'b0;
    init_i         = 1'b0;
    init_credits_i = '0;
    // Request held high through reset, nothing may be granted
    tx_req_i       = 1'b1;
    ret_valid_i    = 1'b0;
    ret_cnt_i      = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (2) begin
      @(negedge clk_i);
      check_eq("tx_grant_o", 32'(tx_grant_o), 32'd0);
      check_eq("credits_o", 32'(credits_o), 32'(ResetCredits));
    end

    // Init with five credits and drain them with a steady request
    drive_link(1'b0, 1'b1, credit_t'(5), 1'b0, 1'b0, '0);
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
    grants = 0;
    repeat (7) begin
      @(negedge clk_i);
      if (tx_grant_o) grants++;
    end
    check_eq("granted flits", 32'(grants), 32'd5);
    check_eq("tx_grant_o", 32'(tx_grant_o), 32'd0);
    check_eq("credits_o", 32'(credits_o), 32'd0);

    // Plain return of three, then grant with return of four nets plus three
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b1, step_t'(3));
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'd3);
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b1, step_t'(4));
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'd6);
    // A return of one cancels the grant in the same cycle
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b1, step_t'(1));
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'd6);

    // Two large returns run into full scale, then three grants count down
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b1, step_t'(200));
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b1, step_t'(200));
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'(FullScale));
    repeat (3) drive_link(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'(FullScale - credit_t'(3)));

    // Clear beats init and return, and grants stay off until a new init
    drive_link(1'b1, 1'b1, credit_t'(9), 1'b1, 1'b1, step_t'(5));
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'(ResetCredits));
    check_eq("tx_grant_o", 32'(tx_grant_o), 32'd0);
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b1, step_t'(4));
    drive_link(1'b0, 1'b0, '0, 1'b1, 1'b0, '0);
    @(negedge clk_i);
    check_eq("credits_o", 32'(credits_o), 32'(ResetCredits + credit_t'(4)));
    check_eq("tx_grant_o", 32'(tx_grant_o), 32'd0);

    // Random traffic with mostly small returns and rare inits
    drive_link(1'b0, 1'b1, credit_t'(12), 1'b0, 1'b0, '0);
    for (int i = 0; i < RandCycles; i++) begin
      rng_state = lcg_next(rng_state);
      r         = rng_state;
      drive_link(1'b0, r[31:27] == 5'd0, credit_t'(r[13:6]), r[26:25] != 2'd0,
                 r[24:23] == 2'd0, r[22] ? step_t'(r[21:14]) : step_t'(r[16:14]));
    end
    drive_link(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
    repeat (2) @(negedge clk_i);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* tb.f */
+incdir+include
hw/hcnt_pkg.sv
hw/cnt_ctrl_if.sv
hw/credit_ctrl.sv
hw/hard_count_lane.sv
hw/count_check.sv
hw/credit_guard_top.sv
testbench/tb_credit_guard.sv

/* Makefile */
# Verilator build and run for the credit counter testbench
# The run target fails when the simulation ends with $fatal

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert \
	  --top-module tb_credit_guard \
	  -f tb.f \
	  -o sim_credit_guard

run: compile
	./obj_dir/sim_credit_guard

clean:
	rm -rf obj_dir
